// ==== rtl/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    localparam int XLEN      = 32;
    localparam int REG_AW    = 5;
    localparam int SHAMT_W   = $clog2(XLEN);
    localparam int WDT_LIMIT = 16;
    localparam int WDT_CNT_W = $clog2(WDT_LIMIT + 1);

    // only OKAY is treated as success, every other code is a bus error
    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU
    } alu_op_e;

    typedef enum logic [3:0] {
        NONE,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,
        JALR
    } br_op_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } mem_size_e;

    typedef struct packed {
        alu_op_e             alu_op;
        logic [XLEN-1:0]     src1;
        logic [XLEN-1:0]     src2;
        br_op_e              br_op;
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     imm;
        logic                mem_ren;
        logic                mem_wen;
        mem_size_e           mem_size;
        logic                mem_unsigned;
        logic [XLEN-1:0]     store_data;
        logic [REG_AW-1:0]   rd;
    } exu_req_t;

    typedef struct packed {
        logic                reg_wen;
        logic [REG_AW-1:0]   rd;
        logic [XLEN-1:0]     wdata;
        logic                redirect;
        logic [XLEN-1:0]     target_pc;
        logic                bus_err;
    } exu_resp_t;

    // one request struct shared by the aw, w and ar channels
    typedef struct packed {
        logic [XLEN-1:0]     addr;
        logic [XLEN-1:0]     wdata;
        logic [3:0]          wstrb;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== rtl/exu_alu.sv ====
`default_nettype none

module exu_alu (
    input  exu_pkg::alu_op_e           alu_op,
    input  logic [exu_pkg::XLEN-1:0]   src1,
    input  logic [exu_pkg::XLEN-1:0]   src2,
    output logic [exu_pkg::XLEN-1:0]   result,
    output logic                       less,
    output logic                       zero
);
    import exu_pkg::*;

    logic               signed_less;
    logic               unsigned_less;
    logic [SHAMT_W-1:0] shamt;

    assign signed_less   = $signed(src1) < $signed(src2);
    assign unsigned_less = src1 < src2;
    assign shamt         = src2[SHAMT_W-1:0];

    // branches pick SLTU for the unsigned compares, everything else compares signed
    assign less = (alu_op == SLTU) ? unsigned_less : signed_less;
    assign zero = (src1 == src2);

    always_comb begin
        case (alu_op)
            ADD:     result = src1 + src2;
            SUB:     result = src1 - src2;
            AND:     result = src1 & src2;
            OR:      result = src1 | src2;
            XOR:     result = src1 ^ src2;
            SLL:     result = src1 << shamt;
            SRL:     result = src1 >> shamt;
            SRA:     result = $unsigned($signed(src1) >>> shamt);
            SLT:     result = {{(XLEN-1){1'b0}}, signed_less};
            SLTU:    result = {{(XLEN-1){1'b0}}, unsigned_less};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/exu_bru.sv ====
`default_nettype none

module exu_bru (
    input  exu_pkg::br_op_e            br_op,
    input  logic [exu_pkg::XLEN-1:0]   pc,
    input  logic [exu_pkg::XLEN-1:0]   imm,
    input  logic [exu_pkg::XLEN-1:0]   sum,
    input  logic                       less,
    input  logic                       zero,
    output logic                       taken,
    output logic [exu_pkg::XLEN-1:0]   target,
    output logic [exu_pkg::XLEN-1:0]   link
);
    import exu_pkg::*;

    always_comb begin
        case (br_op)
            BEQ:       taken = zero;
            BNE:       taken = !zero;
            BLT, BLTU: taken = less;
            BGE, BGEU: taken = !less;
            JAL, JALR: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // jalr takes rs1 + imm from the ALU and drops bit 0
    assign target = (br_op == JALR) ? {sum[XLEN-1:1], 1'b0} : pc + imm;
    assign link   = pc + XLEN'(4);

endmodule

`default_nettype wire

// ==== rtl/lsu_align.sv ====
`default_nettype none

module lsu_align (
    input  logic [1:0]                 addr_lo,
    input  exu_pkg::mem_size_e         size,
    input  logic                       is_unsigned,
    input  logic [exu_pkg::XLEN-1:0]   store_data,
    input  logic [exu_pkg::XLEN-1:0]   load_word,
    output logic [exu_pkg::XLEN-1:0]   wdata,
    output logic [3:0]                 wstrb,
    output logic [exu_pkg::XLEN-1:0]   load_value
);
    import exu_pkg::*;

    logic [XLEN-1:0] byte_lane;
    logic [XLEN-1:0] half_lane;

    // store data is copied into every lane, the strobe selects the one that counts
    always_comb begin
        case (size)
            BYTE: begin
                wdata = {4{store_data[7:0]}};
                wstrb = 4'b0001 << addr_lo;
            end
            HALF: begin
                wdata = {2{store_data[15:0]}};
                wstrb = addr_lo[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata = store_data;
                wstrb = 4'b1111;
            end
        endcase
    end

    assign byte_lane = load_word >> {addr_lo, 3'b000};
    assign half_lane = load_word >> {addr_lo[1], 4'b0000};

    always_comb begin
        case (size)
            BYTE:    load_value = {{(XLEN-8){byte_lane[7] & !is_unsigned}}, byte_lane[7:0]};
            HALF:    load_value = {{(XLEN-16){half_lane[15] & !is_unsigned}}, half_lane[15:0]};
            default: load_value = load_word;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/bus_watchdog.sv ====
`default_nettype none

module bus_watchdog (
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    output logic expired
);
    import exu_pkg::*;

    logic [WDT_CNT_W-1:0] count;

    // the count saturates at the limit so expired stays up until enable drops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!enable) begin
            count <= '0;
        end else if (count != WDT_CNT_W'(WDT_LIMIT)) begin
            count <= count + 1'b1;
        end
    end

    assign expired = enable && (count == WDT_CNT_W'(WDT_LIMIT));

endmodule

`default_nettype wire

// ==== rtl/lsu_fsm.sv ====
`default_nettype none

module lsu_fsm (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       id_valid,
    input  exu_pkg::exu_req_t          id_req,
    input  logic                       wb_ready,
    input  logic [exu_pkg::XLEN-1:0]   alu_result,
    input  logic                       br_taken,
    input  logic [exu_pkg::XLEN-1:0]   br_target,
    input  logic [exu_pkg::XLEN-1:0]   br_link,
    input  logic [exu_pkg::XLEN-1:0]   load_value,
    input  logic                       expired,
    input  logic                       aw_ready,
    input  logic                       w_ready,
    input  logic                       b_valid,
    input  logic [1:0]                 b_resp,
    input  logic                       ar_ready,
    input  logic                       r_valid,
    input  logic [1:0]                 r_resp,
    output logic                       ex_ready,
    output logic                       ex_valid,
    output exu_pkg::exu_resp_t         ex_resp,
    output exu_pkg::exu_req_t          held_req,
    output logic                       aw_valid,
    output logic                       w_valid,
    output logic                       b_ready,
    output logic                       ar_valid,
    output logic                       r_ready,
    output logic                       wd_enable
);
    import exu_pkg::*;

    typedef enum logic [2:0] {IDLE, EXEC, WRITE, WRESP, READ, RRESP, HOLD} state_e;

    state_e    state;
    state_e    state_d;
    logic      aw_valid_d;
    logic      w_valid_d;
    logic      resp_load;
    exu_resp_t resp_d;
    logic      is_jump;
    logic      writes_rd;
    logic      r_ok;

    assign is_jump   = (held_req.br_op == JAL) || (held_req.br_op == JALR);
    assign writes_rd = (held_req.rd != '0) && ((held_req.br_op == NONE) || is_jump);
    assign r_ok      = (r_resp == RESP_OKAY);

    assign ex_ready  = (state == IDLE);
    assign ex_valid  = (state == HOLD);
    assign ar_valid  = (state == READ);
    assign b_ready   = (state == WRESP);
    assign r_ready   = (state == RRESP);
    assign wd_enable = (state == WRITE) || (state == WRESP) ||
                       (state == READ) || (state == RRESP);

    always_comb begin
        state_d    = state;
        aw_valid_d = aw_valid && !aw_ready;
        w_valid_d  = w_valid && !w_ready;
        resp_load  = 1'b0;
        resp_d     = '0;
        resp_d.rd  = held_req.rd;
        case (state)
            IDLE: begin
                if (id_valid) begin
                    state_d = EXEC;
                end
            end
            EXEC: begin
                if (held_req.mem_wen) begin
                    state_d    = WRITE;
                    aw_valid_d = 1'b1;
                    w_valid_d  = 1'b1;
                end else if (held_req.mem_ren) begin
                    state_d = READ;
                end else begin
                    state_d          = HOLD;
                    resp_load        = 1'b1;
                    resp_d.reg_wen   = writes_rd;
                    resp_d.wdata     = is_jump ? br_link : alu_result;
                    resp_d.redirect  = br_taken;
                    resp_d.target_pc = br_taken ? br_target : '0;
                end
            end
            WRITE: begin
                // aw and w may complete in either order
                if (!aw_valid_d && !w_valid_d) begin
                    state_d = WRESP;
                end
            end
            WRESP: begin
                if (b_valid) begin
                    state_d        = HOLD;
                    resp_load      = 1'b1;
                    resp_d.bus_err = (b_resp != RESP_OKAY);
                end
            end
            READ: begin
                if (ar_ready) begin
                    state_d = RRESP;
                end
            end
            RRESP: begin
                if (r_valid) begin
                    state_d        = HOLD;
                    resp_load      = 1'b1;
                    resp_d.reg_wen = r_ok && (held_req.rd != '0);
                    resp_d.wdata   = r_ok ? load_value : '0;
                    resp_d.bus_err = !r_ok;
                end
            end
            HOLD: begin
                if (wb_ready) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase

        // a response arriving in the expiry cycle still wins
        if (wd_enable && expired && !resp_load) begin
            state_d        = HOLD;
            aw_valid_d     = 1'b0;
            w_valid_d      = 1'b0;
            resp_load      = 1'b1;
            resp_d         = '0;
            resp_d.rd      = held_req.rd;
            resp_d.bus_err = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
        end else begin
            state    <= state_d;
            aw_valid <= aw_valid_d;
            w_valid  <= w_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_ready && id_valid) begin
            held_req <= id_req;
        end
        if (resp_load) begin
            ex_resp <= resp_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exu.sv ====
`default_nettype none

module exu (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       id_valid,
    input  exu_pkg::exu_req_t          id_req,
    output logic                       ex_ready,
    output logic                       ex_valid,
    output exu_pkg::exu_resp_t         ex_resp,
    input  logic                       wb_ready,
    output exu_pkg::mem_req_t          mem_req,
    output logic                       aw_valid,
    input  logic                       aw_ready,
    output logic                       w_valid,
    input  logic                       w_ready,
    input  logic                       b_valid,
    output logic                       b_ready,
    input  logic [1:0]                 b_resp,
    output logic                       ar_valid,
    input  logic                       ar_ready,
    input  logic                       r_valid,
    output logic                       r_ready,
    input  logic [exu_pkg::XLEN-1:0]   r_data,
    input  logic [1:0]                 r_resp
);
    import exu_pkg::*;

    exu_req_t        held_req;
    logic [XLEN-1:0] alu_result;
    logic            alu_less;
    logic            alu_zero;
    logic            br_taken;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] br_link;
    logic [XLEN-1:0] st_wdata;
    logic [3:0]      st_wstrb;
    logic [XLEN-1:0] load_value;
    logic            wd_enable;
    logic            wd_expired;

    exu_alu u_alu (
        .alu_op (held_req.alu_op),
        .src1   (held_req.src1  ),
        .src2   (held_req.src2  ),
        .result (alu_result     ),
        .less   (alu_less       ),
        .zero   (alu_zero       )
    );

    exu_bru u_bru (
        .br_op  (held_req.br_op),
        .pc     (held_req.pc   ),
        .imm    (held_req.imm  ),
        .sum    (alu_result    ),
        .less   (alu_less      ),
        .zero   (alu_zero      ),
        .taken  (br_taken      ),
        .target (br_target     ),
        .link   (br_link       )
    );

    // the ALU sum doubles as the load/store address
    lsu_align u_align (
        .addr_lo     (alu_result[1:0]      ),
        .size        (held_req.mem_size    ),
        .is_unsigned (held_req.mem_unsigned),
        .store_data  (held_req.store_data  ),
        .load_word   (r_data               ),
        .wdata       (st_wdata             ),
        .wstrb       (st_wstrb             ),
        .load_value  (load_value           )
    );

    assign mem_req = '{addr: alu_result, wdata: st_wdata, wstrb: st_wstrb};

    bus_watchdog u_wdt (
        .clk     (clk       ),
        .rst_n   (rst_n     ),
        .enable  (wd_enable ),
        .expired (wd_expired)
    );

    lsu_fsm u_fsm (
        .clk        (clk       ),
        .rst_n      (rst_n     ),
        .id_valid   (id_valid  ),
        .id_req     (id_req    ),
        .wb_ready   (wb_ready  ),
        .alu_result (alu_result),
        .br_taken   (br_taken  ),
        .br_target  (br_target ),
        .br_link    (br_link   ),
        .load_value (load_value),
        .expired    (wd_expired),
        .aw_ready   (aw_ready  ),
        .w_ready    (w_ready   ),
        .b_valid    (b_valid   ),
        .b_resp     (b_resp    ),
        .ar_ready   (ar_ready  ),
        .r_valid    (r_valid   ),
        .r_resp     (r_resp    ),
        .ex_ready   (ex_ready  ),
        .ex_valid   (ex_valid  ),
        .ex_resp    (ex_resp   ),
        .held_req   (held_req  ),
        .aw_valid   (aw_valid  ),
        .w_valid    (w_valid   ),
        .b_ready    (b_ready   ),
        .ar_valid   (ar_valid  ),
        .r_ready    (r_ready   ),
        .wd_enable  (wd_enable )
    );

endmodule

`default_nettype wire

// ==== sim/tb_exu.sv ====
`default_nettype none

module tb_exu;
    timeunit 1ns;
    timeprecision 100ps;
    import exu_pkg::*;

    localparam int SEED         = 32'hf28f;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_DELAY    = 5;
    localparam int ALU_REPS     = 3;
    // alu, branches, stores with their loads, then stall, timeout and rd 0 cases
    localparam int NUM_OPS      = 10 * ALU_REPS + 20 + 21 + 7;
    localparam int CYCLE_LIMIT  = NUM_OPS * (WDT_LIMIT + MAX_DELAY + 4) + RESET_CYCLES + 10;

    logic            clk;
    logic            rst_n;
    logic            id_valid;
    exu_req_t        id_req;
    logic            ex_ready;
    logic            ex_valid;
    exu_resp_t       ex_resp;
    logic            wb_ready;
    mem_req_t        mem_req;
    logic            aw_valid;
    logic            aw_ready;
    logic            w_valid;
    logic            w_ready;
    logic            b_valid;
    logic            b_ready;
    logic [1:0]      b_resp;
    logic            ar_valid;
    logic            ar_ready;
    logic            r_valid;
    logic            r_ready;
    logic [XLEN-1:0] r_data;
    logic [1:0]      r_resp;

    logic [XLEN-1:0] bus_mem [0:255];
    logic [XLEN-1:0] ref_mem [0:255];
    mem_req_t        last_req;
    logic            silent;
    int              resp_delay;
    int              checks = 0;
    int              errors = 0;
    int              cycles = 0;

    exu u_exu (
        .clk      (clk     ),
        .rst_n    (rst_n   ),
        .id_valid (id_valid),
        .id_req   (id_req  ),
        .ex_ready (ex_ready),
        .ex_valid (ex_valid),
        .ex_resp  (ex_resp ),
        .wb_ready (wb_ready),
        .mem_req  (mem_req ),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w_valid  (w_valid ),
        .w_ready  (w_ready ),
        .b_valid  (b_valid ),
        .b_ready  (b_ready ),
        .b_resp   (b_resp  ),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r_valid  (r_valid ),
        .r_ready  (r_ready ),
        .r_data   (r_data  ),
        .r_resp   (r_resp  )
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the DUT gave no result within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // all readies stay high, so the responder sees each address phase on one edge
    always begin : responder
        logic [7:0] idx;
        @(posedge clk);
        if (aw_valid && w_valid) begin
            last_req = mem_req;
            idx      = mem_req.addr[9:2];
            for (int k = 0; k < 4; k++) begin
                if (mem_req.wstrb[k]) begin
                    bus_mem[idx][8*k +: 8] = mem_req.wdata[8*k +: 8];
                end
            end
            repeat (resp_delay) @(posedge clk);
            #1;
            b_valid = 1'b1;
            do @(posedge clk); while (!b_ready);
            #1;
            b_valid = 1'b0;
        end else if (ar_valid && !silent) begin
            idx = mem_req.addr[9:2];
            repeat (resp_delay) @(posedge clk);
            #1;
            r_data  = bus_mem[idx];
            r_valid = 1'b1;
            do @(posedge clk); while (!r_ready);
            #1;
            r_valid = 1'b0;
        end
    end

    function automatic logic [XLEN-1:0] fill_word(int i);
        return 32'h9e37_79b9 * 32'(i + 1) ^ 32'(i << 20);
    endfunction

    function automatic logic [XLEN-1:0] alu_model(alu_op_e op, logic [XLEN-1:0] a,
                                                  logic [XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ADD:     return a + b;
            SUB:     return a + ~b + 32'd1;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << sh;
            SRL:     return a >> sh;
            SRA:     return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            SLT:     return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
            SLTU:    return {31'b0, a < b};
            default: return '0;
        endcase
    endfunction

    function automatic logic branch_model(br_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        case (op)
            BEQ:       return a == b;
            BNE:       return a != b;
            BLT:       return $signed(a) < $signed(b);
            BGE:       return $signed(a) >= $signed(b);
            BLTU:      return a < b;
            BGEU:      return a >= b;
            JAL, JALR: return 1'b1;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic exu_resp_t exec_model(exu_req_t req);
        exu_resp_t r;
        logic      jump;
        jump        = (req.br_op == JAL) || (req.br_op == JALR);
        r           = '0;
        r.rd        = req.rd;
        r.reg_wen   = (req.rd != 5'd0) && ((req.br_op == NONE) || jump);
        r.wdata     = jump ? req.pc + 32'd4 : alu_model(req.alu_op, req.src1, req.src2);
        r.redirect  = branch_model(req.br_op, req.src1, req.src2);
        r.target_pc = (req.br_op == JALR) ? (req.src1 + req.src2) & ~32'd1 : req.pc + req.imm;
        return r;
    endfunction

    function automatic mem_req_t store_model(exu_req_t req);
        mem_req_t m;
        int       nbytes;
        m.addr  = req.src1 + req.src2;
        m.wdata = req.store_data << (8 * m.addr[1:0]);
        case (req.mem_size)
            BYTE:    nbytes = 1;
            HALF:    nbytes = 2;
            default: nbytes = 4;
        endcase
        // a lane is written when it lies inside the accessed bytes
        for (int j = 0; j < 4; j++) begin
            m.wstrb[j] = (j >= m.addr[1:0]) && (j < m.addr[1:0] + nbytes);
        end
        return m;
    endfunction

    function automatic logic [XLEN-1:0] load_model(logic [XLEN-1:0] word, logic [1:0] off,
                                                   mem_size_e size, logic uns);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = word[16*off[1] +: 16];
        case (size)
            BYTE:    return uns ? {24'b0, b} : {{24{b[7]}}, b};
            HALF:    return uns ? {16'b0, h} : {{16{h[15]}}, h};
            default: return word;
        endcase
    endfunction

    task automatic expect_cond(input logic cond, input string what);
        checks++;
        if (cond !== 1'b1) begin
            errors++;
            $display("at %0t: %s", $time, what);
        end
    endtask

    // wdata only counts with reg_wen or bus_err, target_pc only with redirect
    task automatic check_resp(input exu_resp_t got, input exu_resp_t exp, input string what);
        logic bad;
        checks++;
        bad = (got.reg_wen !== exp.reg_wen) || (got.rd !== exp.rd) ||
              (got.redirect !== exp.redirect) || (got.bus_err !== exp.bus_err);
        if ((exp.reg_wen || exp.bus_err) && (got.wdata !== exp.wdata)) begin
            bad = 1'b1;
        end
        if (exp.redirect && (got.target_pc !== exp.target_pc)) begin
            bad = 1'b1;
        end
        if (bad) begin
            errors++;
            $display("FAILED %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_mem_req(input mem_req_t got, input mem_req_t exp, input string what);
        logic [XLEN-1:0] mask;
        checks++;
        for (int j = 0; j < 4; j++) begin
            mask[8*j +: 8] = {8{exp.wstrb[j]}};
        end
        if ((got.addr !== exp.addr) || (got.wstrb !== exp.wstrb) ||
            ((got.wdata & mask) !== (exp.wdata & mask))) begin
            errors++;
            $display("FAILED %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // hands one operation to the DUT and returns its result, stall holds wb_ready low
    task automatic execute(input exu_req_t req, input int stall, output exu_resp_t resp);
        exu_resp_t first;
        int        wait_cycles;
        id_req   = req;
        id_valid = 1'b1;
        wb_ready = (stall == 0);
        do @(posedge clk); while (!ex_ready);
        #1;
        id_valid    = 1'b0;
        wait_cycles = 0;
        do begin
            @(posedge clk);
            wait_cycles++;
        end while (!ex_valid);
        // without a bus access the result is up one cycle after the accepting edge
        if (!req.mem_ren && !req.mem_wen) begin
            expect_cond(wait_cycles == 2, "ex_valid did not rise one cycle after acceptance");
        end
        first = ex_resp;
        repeat (stall) begin
            @(posedge clk);
            expect_cond(ex_valid, "ex_valid dropped while writeback was stalled");
            expect_cond(!ex_ready, "ex_ready rose while a result was held");
            check_resp(ex_resp, first, "held result");
        end
        if (stall > 0) begin
            #1;
            wb_ready = 1'b1;
            @(posedge clk);
            expect_cond(ex_valid, "result was lost before writeback took it");
        end
        resp = ex_resp;
        #1;
        expect_cond(!ex_valid, "result was offered a second time");
    endtask

    task automatic check_idle_outputs();
        expect_cond(ex_ready, "ex_ready is low after reset");
        expect_cond(!ex_valid, "ex_valid is high after reset");
        expect_cond(!aw_valid && !w_valid && !ar_valid, "a bus valid is high after reset");
        expect_cond(!b_ready && !r_ready, "a bus ready is high after reset");
    endtask

    task automatic test_alu();
        exu_req_t  req;
        exu_resp_t resp;
        for (int i = 0; i < 10; i++) begin
            for (int n = 0; n < ALU_REPS; n++) begin
                req        = '0;
                req.alu_op = alu_op_e'(i);
                req.src1   = $urandom;
                req.src2   = (n == 0) ? req.src1 : $urandom;
                req.rd     = 5'($urandom_range(31, 1));
                execute(req, 0, resp);
                check_resp(resp, exec_model(req), $sformatf("alu op %0d", i));
            end
        end
    endtask

    task automatic test_branches();
        exu_req_t        req;
        exu_resp_t       resp;
        br_op_e          ops [6];
        alu_op_e         cmp [6];
        logic [XLEN-1:0] pa [3];
        logic [XLEN-1:0] pb [3];
        ops = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
        cmp = '{SUB, SUB, SLT, SLT, SLTU, SLTU};
        // pb[0] lies below pa[0] when signed and above it when unsigned
        pa[0] = $urandom & 32'h7fff_ffff;
        pb[0] = $urandom | 32'h8000_0000;
        pa[1] = pb[0];
        pb[1] = pa[0];
        pa[2] = pa[0];
        pb[2] = pa[0];
        for (int i = 0; i < 6; i++) begin
            for (int p = 0; p < 3; p++) begin
                req        = '0;
                req.br_op  = ops[i];
                req.alu_op = cmp[i];
                req.src1   = pa[p];
                req.src2   = pb[p];
                req.pc     = $urandom & ~32'd3;
                req.imm    = ($urandom & 32'h0000_1ffe) - 32'h0000_1000;
                req.rd     = 5'($urandom_range(31, 1));
                execute(req, 0, resp);
                check_resp(resp, exec_model(req), $sformatf("branch %0d pair %0d", i, p));
            end
        end
        req       = '0;
        req.br_op = JAL;
        req.pc    = $urandom & ~32'd3;
        req.imm   = 32'h0000_0ff0;
        req.rd    = 5'd1;
        execute(req, 0, resp);
        check_resp(resp, exec_model(req), "jal");
        req.br_op  = JALR;
        req.alu_op = ADD;
        req.src1   = $urandom;
        req.src2   = ($urandom & 32'h0000_0fff) | 32'd1;
        req.imm    = req.src2;
        execute(req, 0, resp);
        check_resp(resp, exec_model(req), "jalr");
    endtask

    task automatic test_mem();
        exu_req_t        req;
        exu_resp_t       resp;
        exu_resp_t       exp;
        mem_req_t        exp_req;
        logic [XLEN-1:0] addr;
        int              word;
        word = 32;
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off += (1 << s)) begin
                req                = '0;
                req.alu_op         = ADD;
                req.src1           = 32'(word * 4);
                req.src2           = 32'(off);
                req.mem_wen        = 1'b1;
                req.mem_size       = mem_size_e'(s);
                req.store_data     = $urandom;
                req.store_data[7]  = word[0];
                req.store_data[15] = word[0];
                resp_delay         = word % (MAX_DELAY + 1);
                execute(req, 0, resp);
                exp_req = store_model(req);
                check_resp(resp, '0, "store response");
                check_mem_req(last_req, exp_req, $sformatf("store size %0d offset %0d", s, off));
                for (int j = 0; j < 4; j++) begin
                    if (exp_req.wstrb[j]) begin
                        ref_mem[exp_req.addr[9:2]][8*j +: 8] = exp_req.wdata[8*j +: 8];
                    end
                end
                for (int u = 0; u < 2; u++) begin
                    req.mem_wen      = 1'b0;
                    req.mem_ren      = 1'b1;
                    req.mem_unsigned = u[0];
                    req.rd           = 5'($urandom_range(31, 1));
                    resp_delay       = (word + u + 1) % (MAX_DELAY + 1);
                    execute(req, 0, resp);
                    addr          = req.src1 + req.src2;
                    exp           = '0;
                    exp.reg_wen   = 1'b1;
                    exp.rd        = req.rd;
                    exp.wdata     = load_model(ref_mem[addr[9:2]], addr[1:0],
                                               req.mem_size, req.mem_unsigned);
                    check_resp(resp, exp, $sformatf("load size %0d offset %0d", s, off));
                end
                word++;
            end
        end
    endtask

    task automatic test_backpressure();
        exu_req_t  req;
        exu_resp_t resp;
        req        = '0;
        req.alu_op = XOR;
        req.src1   = $urandom;
        req.src2   = $urandom;
        req.rd     = 5'd7;
        execute(req, 6, resp);
        check_resp(resp, exec_model(req), "stalled result");
    endtask

    task automatic test_bus_timeout();
        exu_req_t  req;
        exu_resp_t resp;
        exu_resp_t exp;
        silent       = 1'b1;
        req          = '0;
        req.alu_op   = ADD;
        req.src1     = 32'h0000_0100;
        req.src2     = 32'd4;
        req.mem_ren  = 1'b1;
        req.mem_size = WORD;
        req.rd       = 5'd9;
        execute(req, 0, resp);
        exp         = '0;
        exp.rd      = 5'd9;
        exp.bus_err = 1'b1;
        check_resp(resp, exp, "load with no bus response");
        silent     = 1'b0;
        resp_delay = 2;
        execute(req, 0, resp);
        exp.bus_err = 1'b0;
        exp.reg_wen = 1'b1;
        exp.wdata   = ref_mem[65];
        check_resp(resp, exp, "load after bus timeout");
        req         = '0;
        req.alu_op  = SUB;
        req.src1    = $urandom;
        req.src2    = $urandom;
        req.rd      = 5'd3;
        execute(req, 0, resp);
        check_resp(resp, exec_model(req), "alu after bus timeout");
    endtask

    task automatic test_rd_zero();
        exu_req_t  req;
        exu_resp_t resp;
        req        = '0;
        req.alu_op = OR;
        req.src1   = $urandom;
        req.src2   = $urandom;
        execute(req, 0, resp);
        check_resp(resp, exec_model(req), "alu to rd 0");
        expect_cond(!resp.reg_wen, "register write enabled for rd 0 by an alu op");
        req.br_op = JAL;
        req.pc    = 32'h0000_2000;
        req.imm   = 32'h0000_0040;
        execute(req, 0, resp);
        check_resp(resp, exec_model(req), "jal to rd 0");
        expect_cond(!resp.reg_wen, "register write enabled for rd 0 by a jump");
        req          = '0;
        req.alu_op   = ADD;
        req.src1     = 32'h0000_0200;
        req.mem_ren  = 1'b1;
        req.mem_size = WORD;
        execute(req, 0, resp);
        expect_cond(!resp.reg_wen, "register write enabled for rd 0 by a load");
        expect_cond(!resp.bus_err, "load to rd 0 reported a bus error");
    endtask

    initial begin
        void'($urandom(SEED));
        clk        = 1'b0;
        rst_n      = 1'b0;
        id_valid   = 1'b0;
        id_req     = '0;
        wb_ready   = 1'b1;
        aw_ready   = 1'b1;
        w_ready    = 1'b1;
        b_valid    = 1'b0;
        b_resp     = 2'b00;
        ar_ready   = 1'b1;
        r_valid    = 1'b0;
        r_data     = '0;
        r_resp     = 2'b00;
        silent     = 1'b0;
        resp_delay = 0;
        for (int i = 0; i < 256; i++) begin
            bus_mem[i] = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_idle_outputs();
        test_alu();
        test_branches();
        test_mem();
        test_backpressure();
        test_bus_timeout();
        test_rd_zero();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/exu_pkg.sv
rtl/exu_alu.sv
rtl/exu_bru.sv
rtl/lsu_align.sv
rtl/bus_watchdog.sv
rtl/lsu_fsm.sv
rtl/exu.sv
sim/tb_exu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run tb_exu with Verilator, the log decides pass or fail
verilator --binary --timing -Wno-fatal --top-module tb_exu -f project.f \
    -Mdir obj_dir -o tb_exu_sim &&
    ./obj_dir/tb_exu_sim > sim.log 2>&1 ||
    { echo "build or run did not complete"; exit 1; }
cat sim.log
grep -q "Simulation passed" sim.log && exit 0 || exit 1
